// File: sim.f
verilog/pea_pkg.sv
verilog/pea_fifo_if.sv
verilog/pea_fifo.sv
verilog/pea_enable.sv
verilog/pea_core.sv
verilog/pea_top.sv
test/pea_clock_gen.sv
test/pea_checker.sv
test/pea_tb.sv

// File: Makefile
# Verilator flow for the polynomial evaluation accelerator
VERILATOR ?= verilator
SIM_DIR   ?= sim_build
TOP       ?= pea_tb
SEED      ?= 55279
FILELIST  ?= sim.f
LOG       ?= $(SIM_DIR)/sim.log
VFLAGS    ?= --assert --timing
RUN_ARGS  ?= +verilator+error+limit+100

BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(SIM_DIR)

run: build
	-$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR)

// File: test/pea_tb.sv
/* Directed tests of pea_top at its default BUFFER_SIZE of 16.
   Every task starts and ends on a falling edge, where inputs change and outputs are read. */
module pea_tb #(
    parameter int SEED = 55279
);
    timeunit 1ns;
    timeprecision 1ps;

    import pea_pkg::*;

    localparam int     TIMEOUT = 1000;                 // Cycles allowed for any single wait
    localparam longint S32_MAX = 2147483647;
    localparam longint S32_MIN = -S32_MAX - 1;

    logic                     clk;
    logic                     rst;
    logic [CTRL_W-1:0]        ctrl_data;
    logic                     ctrl_valid;
    logic                     ctrl_ready;
    logic [DATA_W-1:0]        data_in;
    logic                     data_valid;
    logic                     data_ready;
    logic [RESULT_W-1:0]      result_data;
    logic                     result_valid;
    logic                     result_ready;
    logic [STATUS_W-1:0]      status_data;
    logic                     status_valid;
    logic                     status_ready;
    logic signed [DATA_W-1:0] model_coef [NUM_SLOTS][MAX_TERMS];  // Reference copy of the slots
    int                       model_deg [NUM_SLOTS];

    pea_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    pea_top DUT (
        .clk          (clk),
        .rst          (rst),
        .ctrl_data    (ctrl_data),
        .ctrl_valid   (ctrl_valid),
        .ctrl_ready   (ctrl_ready),
        .data_in      (data_in),
        .data_valid   (data_valid),
        .data_ready   (data_ready),
        .result_data  (result_data),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .status_data  (status_data),
        .status_valid (status_valid),
        .status_ready (status_ready)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input string name, input logic [RESULT_W-1:0] exp,
                                input logic [RESULT_W-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: result expected %0d, actual %0d", name, $signed(exp), $signed(act));
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input logic [STATUS_W-1:0] exp,
                                input logic [STATUS_W-1:0] act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: status expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    function automatic void model_clear();
        foreach (model_coef[s, k])
            model_coef[s][k] = '0;
        foreach (model_deg[s])
            model_deg[s] = 0;                          // Degree 0 with a zero coefficient
    endfunction

    // Horner's rule on exact 64-bit values that wrap to 32 bits after every step
    function automatic logic [RESULT_W-1:0] model_eval(input int s,
                                                       input logic signed [DATA_W-1:0] x,
                                                       output logic [STATUS_W-1:0] st);
        longint acc;
        longint step;
        st  = STATUS_OK;
        acc = 0;
        for (int k = 0; k <= model_deg[s]; k++)
        begin
            step = acc * longint'(x) + longint'(model_coef[s][k]);
            if (step > S32_MAX || step < S32_MIN)
                st = STATUS_OVERFLOW;                  // Sticky for the whole evaluation
            acc = longint'(int'(step));                // Keeps the low 32 bits and sign extends them
        end
        return RESULT_W'(acc);
    endfunction

    task automatic send_command(input logic [OPCODE_W-1:0] op, input int slot, input int arg);
        int waited;
        waited     = 0;
        ctrl_data  = {op, ARG1_W'(slot), ARG2_W'(arg)};
        ctrl_valid = 1'b1;
        while (!ctrl_ready)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Timeout: the command queue never accepted a command");
                abort_run();
            end
        end
        @(negedge clk);                                // Taken on the rising edge just passed
        ctrl_valid = 1'b0;
    endtask

    task automatic send_data(input logic signed [DATA_W-1:0] value);
        int waited;
        waited     = 0;
        data_in    = value;
        data_valid = 1'b1;
        while (!data_ready)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Timeout: the data queue never accepted a token");
                abort_run();
            end
        end
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    task automatic take_output(input string name, input logic [RESULT_W-1:0] exp_res,
                               input logic [STATUS_W-1:0] exp_st, input int hold);
        int waited;
        waited = 0;
        while (!result_valid)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Timeout: no result arrived for test %s", name);
                abort_run();
            end
        end
        repeat (hold) @(negedge clk);                  // The head word must hold while ready is low
        check_result(name, exp_res, result_data);
        check_status(name, exp_st, status_data);
        result_ready = 1'b1;
        status_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        status_ready = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            if (result_valid || status_valid)
            begin
                $display("Output appeared before the x it needs was sent");
                abort_run();
            end
        end
    endtask

    task automatic store_poly(input int slot, input logic signed [DATA_W-1:0] c [$]);
        send_command(OP_STP, slot, c.size() - 1);      // b is the degree
        foreach (c[k])
        begin
            send_data(c[k]);
            model_coef[slot][k] = c[k];                // Highest power first
        end
        model_deg[slot] = c.size() - 1;
    endtask

    task automatic eval_one(input string name, input int slot, input logic signed [DATA_W-1:0] x);
        logic [RESULT_W-1:0] exp_res;
        logic [STATUS_W-1:0] exp_st;
        exp_res = model_eval(slot, x, exp_st);
        send_command(OP_EVP, slot, 0);
        send_data(x);
        take_output(name, exp_res, exp_st, 0);
    endtask

    task automatic test_store_eval();
        logic signed [DATA_W-1:0] c [$];
        logic signed [DATA_W-1:0] x;
        c = '{16'sd3, -16'sd5, 16'sd7, 16'sd11};
        store_poly(2, c);
        x = DATA_W'($urandom_range(200)) - 16'sd100;   // Small x keeps the cubic in range
        eval_one("store_eval", 2, x);
    endtask

    task automatic test_batch();
        logic signed [DATA_W-1:0] xs [10];
        logic [RESULT_W-1:0]      exp_res [10];
        logic [STATUS_W-1:0]      exp_st [10];
        send_command(OP_EVB, 2, 10);
        foreach (xs[i])
        begin
            xs[i]      = DATA_W'($urandom);
            exp_res[i] = model_eval(2, xs[i], exp_st[i]);
            send_data(xs[i]);
        end
        // Ready held low for 1 to 3 cycles before each transfer
        foreach (xs[i])
            take_output("batch", exp_res[i], exp_st[i], int'($urandom_range(3, 1)));
    endtask

    task automatic test_overflow();
        logic signed [DATA_W-1:0] c [$];
        logic signed [DATA_W-1:0] xs [4];
        c  = '{16'sh7FFF, -16'sh7FFF, 16'sh7FFF, 16'sh7FFF};
        xs = '{16'sh7FFF, -16'sh8000, 16'sd1, DATA_W'($urandom)};  // x of 1 stays in range
        store_poly(5, c);
        foreach (xs[i])
            eval_one("overflow", 5, xs[i]);
    endtask

    task automatic test_clear();
        send_command(OP_RST, 0, 0);
        model_clear();
        eval_one("clear_slot2", 2, DATA_W'($urandom));
        eval_one("clear_slot5", 5, DATA_W'($urandom));
    endtask

    task automatic test_waits_and_drops();
        logic signed [DATA_W-1:0] c [$];
        logic [RESULT_W-1:0]      exp_res;
        logic [STATUS_W-1:0]      exp_st;
        c = '{-16'sd2, 16'sd9};
        store_poly(3, c);
        exp_res = model_eval(3, 16'sd21, exp_st);
        send_command(OP_EVP, 3, 0);
        expect_quiet(30);                              // Core sits in EVP with no x queued
        send_data(16'sd21);
        take_output("evp_waits_for_x", exp_res, exp_st, 0);
        send_command(8'hA5, 1, 7);                     // Undefined opcode
        send_command(OP_EVB, 1, 0);                    // Batch of zero
        eval_one("after_drops", 3, DATA_W'($urandom));
    endtask

    initial
    begin
        int waited;
        ctrl_data    = '0;
        ctrl_valid   = 1'b0;
        data_in      = '0;
        data_valid   = 1'b0;
        result_ready = 1'b0;
        status_ready = 1'b0;
        void'($urandom(SEED));
        model_clear();
        waited = 0;
        @(posedge clk);
        while (rst)                                    // Reset only changes on falling edges
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Timeout: reset was never released");
                abort_run();
            end
        end
        @(negedge clk);
        test_store_eval();
        test_batch();
        test_overflow();
        test_clear();
        test_waits_and_drops();
        if (DUT.u_checker.total_fails == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures in the stream checker", DUT.u_checker.total_fails);
            $display("Testbench failed");
            $fatal(1, "stream checker reported errors");
        end
    end

endmodule

// File: test/pea_checker.sv
/* Protocol checks on the two output streams of pea_top.
   Assumes result_ready and status_ready are always driven together. */
module pea_checker (
    input logic                         clk,
    input logic                         rst,
    input logic [pea_pkg::RESULT_W-1:0] result_data,
    input logic                         result_valid,
    input logic                         result_ready,
    input logic [pea_pkg::STATUS_W-1:0] status_data,
    input logic                         status_valid,
    input logic                         status_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned reset_fails       = 0;
    int unsigned result_hold_fails = 0;
    int unsigned status_hold_fails = 0;
    int unsigned pair_fails        = 0;
    int unsigned total_fails;                          // Read by the testbench at the end

    assign total_fails = reset_fails + result_hold_fails + status_hold_fails + pair_fails;

    // Queues are empty on the edge after a reset edge
    quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !result_valid && !status_valid)
        else begin $error("output valid during reset"); reset_fails++; end

    result_held: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result_data))
        else begin $error("result changed while stalled"); result_hold_fails++; end

    status_held: assert property (@(posedge clk) disable iff (rst)
        status_valid && !status_ready |=> status_valid && $stable(status_data))
        else begin $error("status changed while stalled"); status_hold_fails++; end

    // Core pushes both queues on the same edge
    result_with_status: assert property (@(posedge clk) disable iff (rst)
        result_valid == status_valid)
        else begin $error("result and status out of step"); pair_fails++; end

endmodule

bind pea_top pea_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .status_data  (status_data),
    .status_valid (status_valid),
    .status_ready (status_ready)
);

// File: test/pea_clock_gen.sv
/* 20 ns clock, reset high for the first 5 rising edges, released on a falling edge. */
module pea_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);  // Reset is synchronous so it must see these edges
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verilog/pea_top.sv
/* Polynomial evaluation accelerator with valid/ready streams on every port.
   A transfer happens on an edge where valid and ready are both high. */
module pea_top #(
    parameter int BUFFER_SIZE = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [pea_pkg::CTRL_W-1:0]   ctrl_data,
    input  logic                         ctrl_valid,
    output logic                         ctrl_ready,
    input  logic [pea_pkg::DATA_W-1:0]   data_in,
    input  logic                         data_valid,
    output logic                         data_ready,
    output logic [pea_pkg::RESULT_W-1:0] result_data,
    output logic                         result_valid,
    input  logic                         result_ready,
    output logic [pea_pkg::STATUS_W-1:0] status_data,
    output logic                         status_valid,
    input  logic                         status_ready
);

    import pea_pkg::*;

    logic       enable;
    logic [2:0] mode;
    logic [ARG2_W-1:0] b;

    pea_fifo_if #(.WIDTH(CTRL_W),   .DEPTH(BUFFER_SIZE)) ctrl_q ();
    pea_fifo_if #(.WIDTH(DATA_W),   .DEPTH(BUFFER_SIZE)) data_q ();
    pea_fifo_if #(.WIDTH(RESULT_W), .DEPTH(BUFFER_SIZE)) result_q ();
    pea_fifo_if #(.WIDTH(STATUS_W), .DEPTH(BUFFER_SIZE)) status_q ();

    // Input streams; the queue ignores a push while full, which matches ready low
    assign ctrl_q.push      = ctrl_valid;
    assign ctrl_q.push_data = ctrl_data;
    assign ctrl_ready       = !ctrl_q.full;
    assign data_q.push      = data_valid;
    assign data_q.push_data = data_in;
    assign data_ready       = !data_q.full;

    // Output streams, head word held until taken
    assign result_data  = result_q.pop_data;
    assign result_valid = !result_q.empty;
    assign result_q.pop = result_valid && result_ready;
    assign status_data  = status_q.pop_data;
    assign status_valid = !status_q.empty;
    assign status_q.pop = status_valid && status_ready;

    pea_fifo #(.WIDTH(CTRL_W),   .DEPTH(BUFFER_SIZE)) u_ctrl_fifo   (.clk, .rst, .q(ctrl_q));
    pea_fifo #(.WIDTH(DATA_W),   .DEPTH(BUFFER_SIZE)) u_data_fifo   (.clk, .rst, .q(data_q));
    pea_fifo #(.WIDTH(RESULT_W), .DEPTH(BUFFER_SIZE)) u_result_fifo (.clk, .rst, .q(result_q));
    pea_fifo #(.WIDTH(STATUS_W), .DEPTH(BUFFER_SIZE)) u_status_fifo (.clk, .rst, .q(status_q));

    pea_enable #(.BUFFER_SIZE(BUFFER_SIZE)) u_enable (
        .mode              (mode),
        .b                 (b),
        .control_count     (ctrl_q.count),
        .data_count        (data_q.count),
        .result_free_space (result_q.free_space),
        .status_free_space (status_q.free_space),
        .enable            (enable)
    );

    pea_core #(.BUFFER_SIZE(BUFFER_SIZE)) u_core (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl_q.reader),
        .data   (data_q.reader),
        .result (result_q.writer),
        .status (status_q.writer),
        .enable (enable),
        .mode   (mode),
        .b      (b)
    );

endmodule

// File: verilog/pea_core.sv
/* Command FSM, coefficient memory, Horner datapath and output writer.
   A command whose tokens exceed BUFFER_SIZE could never fire, so it is dropped. */
module pea_core #(
    parameter int BUFFER_SIZE = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    pea_fifo_if.reader                 ctrl,
    pea_fifo_if.reader                 data,
    pea_fifo_if.writer                 result,
    pea_fifo_if.writer                 status,
    input  logic                       enable,
    output logic [2:0]                 mode,
    output logic [pea_pkg::ARG2_W-1:0] b              // Tokens still to move in this mode
);

    import pea_pkg::*;

    localparam int TERM_W = $clog2(MAX_TERMS);
    localparam int WIDE_W = RESULT_W + DATA_W + 1;     // Exact width of acc*x + c

    logic signed [DATA_W-1:0]   coef_mem [NUM_SLOTS*MAX_TERMS];  // Highest power at term 0
    logic [ARG2_W-1:0]          deg_mem  [NUM_SLOTS];
    logic [RESULT_W-1:0]        stage_res [MAX_TERMS];           // Results wait here
    logic [STATUS_W-1:0]        stage_st  [MAX_TERMS];
    logic [OPCODE_W-1:0]        cmd_op;
    logic [ARG1_W-1:0]          cmd_arg1;
    logic [ARG2_W-1:0]          cmd_arg2;
    logic [ARG1_W-1:0]          slot;
    logic [ARG2_W-1:0]          n_total;          // Results of this evaluation
    logic [TERM_W-1:0]          k;                // Coefficient index
    logic [TERM_W-1:0]          idx;              // Staging index
    logic                       busy;             // Horner steps running for one x
    logic                       ev_mode;
    logic                       last_step;
    logic signed [DATA_W-1:0]   x_reg;
    logic signed [RESULT_W-1:0] acc;
    logic                       ov;               // Sticky overflow for this x
    logic signed [WIDE_W-1:0]   step_full;
    logic signed [RESULT_W-1:0] step_wrap;
    logic                       step_ov;
    logic                       fits_stp;
    logic                       fits_evb;

    assign cmd_op   = ctrl.pop_data[CTRL_W-1 -: OPCODE_W];
    assign cmd_arg1 = ctrl.pop_data[ARG2_W +: ARG1_W];
    assign cmd_arg2 = ctrl.pop_data[ARG2_W-1:0];
    assign fits_stp = (int'(cmd_arg2) < BUFFER_SIZE);    // b+1 words must fit the data queue
    assign fits_evb = (cmd_arg2 != '0) && (int'(cmd_arg2) <= BUFFER_SIZE);

    assign ev_mode   = (mode == MODE_EVP) || (mode == MODE_EVB);
    assign last_step = busy && (k == deg_mem[slot]);

    // One Horner step, kept exact so that leaving 32 bits can be seen
    assign step_full = WIDE_W'(acc) * WIDE_W'(x_reg) + WIDE_W'(coef_mem[{slot, k}]);
    assign step_wrap = step_full[RESULT_W-1:0];
    assign step_ov   = (step_full != WIDE_W'(step_wrap));

    // Token moves happen only on a cycle where the firing rule holds
    assign ctrl.pop  = (mode == MODE_GET_COMMAND) && enable;
    assign data.pop  = enable && ((mode == MODE_STP) || (ev_mode && !busy));
    assign result.push      = (mode == MODE_OUTPUT) && enable;
    assign status.push      = result.push;                 // A result and its status travel together
    assign result.push_data = stage_res[idx];
    assign status.push_data = stage_st[idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode    <= MODE_GET_COMMAND;
            b       <= '0;
            n_total <= '0;
            slot    <= '0;
            k       <= '0;
            idx     <= '0;
            busy    <= 1'b0;
        end
        else
        begin
            case (mode)
                MODE_GET_COMMAND:
                begin
                    if (enable)
                    begin
                        slot    <= cmd_arg1;
                        b       <= cmd_arg2;
                        n_total <= cmd_arg2;
                        k       <= '0;
                        idx     <= '0;
                        if (cmd_op == OP_STP && fits_stp)
                            mode <= MODE_STP;
                        else if (cmd_op == OP_EVB && fits_evb)
                            mode <= MODE_EVB;
                        else if (cmd_op == OP_RST)
                            mode <= MODE_RST;
                        else if (cmd_op == OP_EVP)
                        begin
                            mode    <= MODE_EVP;
                            b       <= ARG2_W'(1);             // One x, one result
                            n_total <= ARG2_W'(1);
                        end
                    end
                end
                MODE_STP:
                begin
                    if (enable)
                    begin
                        k <= k + TERM_W'(1);
                        if (b == '0)
                            mode <= MODE_GET_COMMAND;
                        else
                            b <= b - ARG2_W'(1);
                    end
                end
                MODE_EVP, MODE_EVB:
                begin
                    if (!busy && enable)
                    begin
                        busy <= 1'b1;                          // x popped, steps start next cycle
                        k    <= '0;
                        b    <= b - ARG2_W'(1);
                    end
                    else if (busy)
                    begin
                        k <= k + TERM_W'(1);
                        if (last_step)
                        begin
                            busy <= 1'b0;
                            idx  <= idx + TERM_W'(1);
                            if (b == '0)
                            begin
                                mode <= MODE_OUTPUT;
                                b    <= n_total;
                                idx  <= '0;
                            end
                        end
                    end
                end
                MODE_RST:
                    mode <= MODE_GET_COMMAND;                  // Memory clears in this cycle
                MODE_OUTPUT:
                begin
                    if (enable)
                    begin
                        idx <= idx + TERM_W'(1);
                        if (b == ARG2_W'(1))
                            mode <= MODE_GET_COMMAND;
                        else
                            b <= b - ARG2_W'(1);
                    end
                end
                default:
                    mode <= MODE_GET_COMMAND;
            endcase
        end
    end

    // Coefficients and degrees are zero after reset and after an RST command
    always_ff @(posedge clk)
    begin
        if (rst || mode == MODE_RST)
        begin
            for (int i = 0; i < NUM_SLOTS * MAX_TERMS; i++)
                coef_mem[i] <= '0;
            for (int s = 0; s < NUM_SLOTS; s++)
                deg_mem[s] <= '0;
        end
        else
        begin
            if (ctrl.pop && cmd_op == OP_STP && fits_stp)
                deg_mem[cmd_arg1] <= cmd_arg2;                 // Degree is the last b stored
            if (data.pop && mode == MODE_STP)
                coef_mem[{slot, k}] <= data.pop_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (data.pop && ev_mode)
        begin
            x_reg <= data.pop_data;
            acc   <= '0;                                       // First step yields the top coefficient
            ov    <= 1'b0;
        end
        else if (busy)
        begin
            acc <= step_wrap;
            ov  <= ov || step_ov;
        end
        if (last_step)
        begin
            stage_res[idx] <= step_wrap;
            stage_st[idx]  <= (ov || step_ov) ? STATUS_OVERFLOW : STATUS_OK;
        end
    end

endmodule

// File: verilog/pea_enable.sv
/* Firing rule of the actor, purely combinational with no state.
   The core lowers b as a firing proceeds, so the rule holds until the firing ends. */
module pea_enable #(
    parameter  int BUFFER_SIZE = 16,
    localparam int CNT_W       = $clog2(BUFFER_SIZE + 1)
) (
    input  logic [2:0]              mode,               // Current FSM mode of the core
    input  logic [pea_pkg::ARG2_W-1:0] b,               // Tokens still needed by the mode
    input  logic [CNT_W-1:0]        control_count,
    input  logic [CNT_W-1:0]        data_count,
    input  logic [CNT_W-1:0]        result_free_space,
    input  logic [CNT_W-1:0]        status_free_space,
    output logic                    enable
);

    import pea_pkg::*;

    int ctrl_n;     // Counts widened for comparison against b
    int data_n;
    int res_n;
    int stat_n;
    int need_b;

    assign ctrl_n = int'(control_count);
    assign data_n = int'(data_count);
    assign res_n  = int'(result_free_space);
    assign stat_n = int'(status_free_space);
    assign need_b = int'(b);

    always_comb
    begin
        case (mode)
            MODE_GET_COMMAND: enable = (ctrl_n >= 1);             // One command waiting
            MODE_STP:         enable = (data_n >= need_b + 1);    // Remaining coefficients
            MODE_EVP:         enable = (data_n >= 1);             // The single x
            MODE_EVB:         enable = (data_n >= need_b);        // Remaining x values
            MODE_RST:         enable = 1'b1;                      // Clearing needs no tokens
            MODE_OUTPUT:      enable = (res_n >= need_b) && (stat_n >= need_b);
            default:          enable = 1'b0;
        endcase
    end

endmodule

// File: verilog/pea_fifo.sv
/* First-word-fall-through FIFO in which a pushed word shows at pop_data the next cycle.
   A push when full or a pop when empty is ignored; DEPTH need not be a power of two. */
module pea_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    pea_fifo_if.store q
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];      // Word storage
    logic [PTR_W-1:0] wr_ptr;           // Next slot to write
    logic [PTR_W-1:0] rd_ptr;           // Head of the queue
    logic [CNT_W-1:0] used;             // Occupancy counter
    logic             do_push;
    logic             do_pop;

    assign do_push = q.push && !q.full;  // Overflowing writes are dropped
    assign do_pop  = q.pop && !q.empty;  // Popping an empty queue does nothing

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= q.push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            if (do_push && !do_pop)
                used <= used + CNT_W'(1);
            else if (do_pop && !do_push)
                used <= used - CNT_W'(1);
        end
    end

    assign q.pop_data   = mem[rd_ptr];          // Head word falls through
    assign q.empty      = (used == '0);
    assign q.full       = (used == CNT_W'(DEPTH));
    assign q.count      = used;
    assign q.free_space = CNT_W'(DEPTH) - used;

endmodule

// File: verilog/pea_fifo_if.sv
/* One FIFO's push side, pop side and occupancy. Counts run from 0 to DEPTH
   inclusive, so they are one bit wider than a pointer when DEPTH is a power of two. */
interface pea_fifo_if #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) ();

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             push;        // Producer writes push_data on this edge
    logic [WIDTH-1:0] push_data;
    logic             full;
    logic             pop;         // Consumer takes pop_data on this edge
    logic [WIDTH-1:0] pop_data;    // Head word, valid while empty is low
    logic             empty;
    logic [CNT_W-1:0] count;       // Words held
    logic [CNT_W-1:0] free_space;  // Words that can still be pushed

    // The buffer itself
    modport store (input push, push_data, pop, output full, pop_data, empty, count, free_space);

    // Consumer side
    modport reader (output pop, input pop_data, empty, count);

    // Producer side
    modport writer (output push, push_data, input full, free_space);

endinterface

// File: verilog/pea_pkg.sv
/* Token widths, opcodes, FSM modes and status codes shared by the accelerator.
   NUM_SLOTS follows ARG1_W; a command is {opcode, arg1, arg2} from high bits to low. */
package pea_pkg;

    // Token widths
    localparam int CTRL_W   = 16;                      // Command token
    localparam int DATA_W   = 16;                      // Data token and coefficient, signed
    localparam int RESULT_W = 32;                      // Result token, signed two's complement
    localparam int STATUS_W = 4;                       // Status token

    // Command fields, high bits to low
    localparam int OPCODE_W = 8;
    localparam int ARG1_W   = 3;                       // Slot number
    localparam int ARG2_W   = 5;                       // The b argument

    localparam int NUM_SLOTS = 1 << ARG1_W;            // One slot per arg1 value
    localparam int MAX_TERMS = 32;                     // Coefficients per slot

    // Opcodes
    localparam logic [OPCODE_W-1:0] OP_STP = 8'd1;     // Store b+1 coefficients
    localparam logic [OPCODE_W-1:0] OP_EVP = 8'd2;     // Evaluate at one x
    localparam logic [OPCODE_W-1:0] OP_EVB = 8'd3;     // Evaluate at b values of x
    localparam logic [OPCODE_W-1:0] OP_RST = 8'd4;     // Clear every slot

    // FSM modes, also decoded by the firing rule
    localparam logic [2:0] MODE_GET_COMMAND = 3'd0;
    localparam logic [2:0] MODE_STP         = 3'd1;
    localparam logic [2:0] MODE_EVP         = 3'd2;
    localparam logic [2:0] MODE_EVB         = 3'd3;
    localparam logic [2:0] MODE_RST         = 3'd4;
    localparam logic [2:0] MODE_OUTPUT      = 3'd5;

    // Status tokens
    localparam logic [STATUS_W-1:0] STATUS_OK       = 4'd0;
    localparam logic [STATUS_W-1:0] STATUS_OVERFLOW = 4'd1;  // Some Horner step left 32 bits

endpackage
